/* verilog.f */
+incdir+.
mem_pkg.sv
dp_byte_ram.sv
axi_read_port.sv
data_port_ctrl.sv
mmio_sink.sv
axi_mm_ram.sv
tb_clock_gen.sv
tb_axi_mm_ram.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_mm_ram
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_axi_mm_ram.sv */
`include "mem_params.svh"

module tb_axi_mm_ram;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;
  localparam int MAX_STALL    = 7;    // longest r_ready/b_ready hold-off
  localparam int NUM_TXN      = 100;  // upper bound on transactions of all tests
  localparam int WAIT_LIMIT   = 40;   // cycles one handshake may take

  logic               clk;
  logic               reset;
  logic               iar_valid;
  logic               iar_ready;
  mem_pkg::addr_req_t iar;
  logic               ir_valid;
  logic               ir_ready;
  mem_pkg::rdata_t    ir;
  logic               dar_valid;
  logic               dar_ready;
  mem_pkg::addr_req_t dar;
  logic               dr_valid;
  logic               dr_ready;
  mem_pkg::rdata_t    dr;
  logic               daw_valid;
  logic               daw_ready;
  mem_pkg::addr_req_t daw;
  logic               dw_valid;
  logic               dw_ready;
  mem_pkg::wdata_t    dw;
  logic               db_valid;
  logic               db_ready;
  mem_pkg::bresp_t    db;
  logic               print_valid;
  logic [7:0]         print_char;
  logic               exit_valid;
  logic [31:0]        exit_value;

  logic [31:0] shadow [1 << `MEM_INDEX_W];  // expected ram contents
  int          seed;
  int          errors;
  int          checks;
  int          tests;
  int          print_count;                 // strobe cycles seen
  int          exit_count;
  logic [1:0]  strobe_at_b;                 // {print, exit} when b_valid first rose

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clk (
    .clk_o  (clk),
    .reset_o(reset)
  );

  axi_mm_ram u_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .iar_valid_i  (iar_valid),
    .iar_ready_o  (iar_ready),
    .iar_i        (iar),
    .ir_valid_o   (ir_valid),
    .ir_ready_i   (ir_ready),
    .ir_o         (ir),
    .dar_valid_i  (dar_valid),
    .dar_ready_o  (dar_ready),
    .dar_i        (dar),
    .dr_valid_o   (dr_valid),
    .dr_ready_i   (dr_ready),
    .dr_o         (dr),
    .daw_valid_i  (daw_valid),
    .daw_ready_o  (daw_ready),
    .daw_i        (daw),
    .dw_valid_i   (dw_valid),
    .dw_ready_o   (dw_ready),
    .dw_i         (dw),
    .db_valid_o   (db_valid),
    .db_ready_i   (db_ready),
    .db_o         (db),
    .print_valid_o(print_valid),
    .print_char_o (print_char),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value)
  );

  // a one-cycle strobe adds exactly one
  always @(negedge clk) begin
    if (!reset && print_valid) begin
      print_count++;
    end
    if (!reset && exit_valid) begin
      exit_count++;
    end
  end

  initial begin
    repeat (RESET_CYCLES + NUM_TXN * (MAX_STALL + 4)) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%s done, %0d errors", name, errors - err_before);
  endtask

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] w;
    w = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        w[i*8 +: 8] = new_word[i*8 +: 8];  // chosen lane only
      end
    end
    return w;
  endfunction

  // entered and left on a falling edge
  task automatic write_data(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall,
                            output logic [1:0] resp);
    int         n;
    logic [1:0] held;
    daw_valid = 1'b1;
    daw.addr  = addr;
    dw_valid  = 1'b1;
    dw.data   = data;
    dw.strb   = strb;
    n = 0;
    #1;                                          // let ready settle
    while (!(daw_ready && dw_ready) && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n == WAIT_LIMIT) begin
      report_error("write address and data never accepted");
    end
    @(negedge clk);                              // joint handshake on the edge between
    daw_valid = 1'b0;
    dw_valid  = 1'b0;
    n = 0;
    while (!db_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_value("b latency", 1, n);
    check_value("daw_ready while pending", 0, 32'(daw_ready));  // valids low, write pending
    check_value("dw_ready while pending", 0, 32'(dw_ready));
    strobe_at_b = {print_valid, exit_valid};
    held = db;
    repeat (stall) begin
      @(negedge clk);
      check_value("db_valid stalled", 1, 32'(db_valid));
      check_value("db stalled", 32'(held), 32'(db));
    end
    db_ready = 1'b1;
    @(negedge clk);
    db_ready = 1'b0;
    check_value("db_valid after handshake", 0, 32'(db_valid));
    resp = held;
  endtask

  task automatic read_port(input bit iside, input logic [31:0] addr, input int stall,
                           output mem_pkg::rdata_t rsp);
    int              n;
    mem_pkg::rdata_t held;
    if (iside) begin
      iar_valid = 1'b1;
      iar.addr  = addr;
    end else begin
      dar_valid = 1'b1;
      dar.addr  = addr;
    end
    n = 0;
    #1;
    while (!(iside ? iar_ready : dar_ready) && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n == WAIT_LIMIT) begin
      report_error("read address never accepted");
    end
    @(negedge clk);
    iar_valid = 1'b0;
    dar_valid = 1'b0;
    n = 0;
    while (!(iside ? ir_valid : dr_valid) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_value("r latency", 2, n);              // ram cycle plus response register
    held = iside ? ir : dr;
    repeat (stall) begin
      @(negedge clk);
      check_value("r_valid stalled", 1, 32'(iside ? ir_valid : dr_valid));
      check_value("r data stalled", held.data, iside ? ir.data : dr.data);
      check_value("r resp stalled", 32'(held.resp), 32'(iside ? ir.resp : dr.resp));
    end
    if (iside) begin
      ir_ready = 1'b1;
    end else begin
      dr_ready = 1'b1;
    end
    @(negedge clk);
    ir_ready = 1'b0;
    dr_ready = 1'b0;
    check_value("r_valid after handshake", 0, 32'(iside ? ir_valid : dr_valid));
    rsp = held;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall);
    logic [1:0] resp;
    write_data(addr, data, strb, stall, resp);
    check_value("db resp", 32'(`MEM_RESP_OKAY), 32'(resp));
    shadow[addr[`MEM_INDEX_W+1:2]] = merge_lanes(shadow[addr[`MEM_INDEX_W+1:2]], data, strb);
  endtask

  // both ports must agree with the shadow word
  task automatic expect_ram(input logic [31:0] addr, input int stall);
    mem_pkg::rdata_t rsp;
    read_port(1'b1, addr, stall, rsp);
    check_value("ir data", shadow[addr[`MEM_INDEX_W+1:2]], rsp.data);
    check_value("ir resp", 32'(`MEM_RESP_OKAY), 32'(rsp.resp));
    read_port(1'b0, addr, stall, rsp);
    check_value("dr data", shadow[addr[`MEM_INDEX_W+1:2]], rsp.data);
    check_value("dr resp", 32'(`MEM_RESP_OKAY), 32'(rsp.resp));
  endtask

  task automatic expect_slverr(input bit iside, input logic [31:0] addr);
    mem_pkg::rdata_t rsp;
    read_port(iside, addr, 0, rsp);
    check_value("r data out of range", 0, rsp.data);
    check_value("r resp out of range", 32'(`MEM_RESP_SLVERR), 32'(rsp.resp));
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic check_reset_state();
    int e;
    e = errors;
    check_value("ir_valid", 0, 32'(ir_valid));
    check_value("dr_valid", 0, 32'(dr_valid));
    check_value("db_valid", 0, 32'(db_valid));
    check_value("print_valid", 0, 32'(print_valid));
    check_value("exit_valid", 0, 32'(exit_valid));
    check_value("iar_ready", 1, 32'(iar_ready));
    check_value("dar_ready", 1, 32'(dar_ready));
    report_test("reset state", e);
  endtask

  task automatic full_word_rw();
    int          e;
    logic [31:0] a;
    e = errors;
    for (int i = 0; i < 8; i++) begin
      a = 32'((i * 37 + 5) * 4);               // spread over the window
      store_word(a, $random(seed), 4'hf, 0);
      expect_ram(a, 0);
    end
    report_test("full word write/read", e);
  endtask

  task automatic byte_lane_writes();
    int e;
    e = errors;
    store_word(32'h0000_0a40, $random(seed), 4'hf, 0);  // defined starting word
    for (int s = 1; s < 15; s++) begin
      store_word(32'h0000_0a40, $random(seed), 4'(s), 0);
    end
    expect_ram(32'h0000_0a40, 0);
    report_test("byte lane writes", e);
  endtask

  task automatic back_pressure();
    int          e;
    logic [31:0] a;
    e = errors;
    for (int i = 0; i < 6; i++) begin
      a = $random(seed) & 32'h0000_0ffc;       // word aligned, inside the window
      store_word(a, $random(seed), 4'hf, $unsigned($random(seed)) % (MAX_STALL + 1));
      expect_ram(a, $unsigned($random(seed)) % (MAX_STALL + 1));
    end
    report_test("back-pressure", e);
  endtask

  task automatic hook_writes();
    int         e;
    int         p;
    int         x;
    logic [1:0] resp;
    e = errors;
    store_word(32'h0, $random(seed), 4'hf, 0);    // ram words the hooks alias
    store_word(32'h4, $random(seed), 4'hf, 0);
    store_word(32'h10, $random(seed), 4'hf, 0);
    p = print_count;
    x = exit_count;
    write_data(`MEM_PRINT_ADDR, 32'h5a5a_5a41, 4'hf, 0, resp);
    check_value("print resp", 32'(`MEM_RESP_OKAY), 32'(resp));
    check_value("strobes at b, print", 32'b10, 32'(strobe_at_b));
    check_value("print strobes", p + 1, print_count);
    check_value("print_char", 32'h41, 32'(print_char));
    write_data(`MEM_EXIT_ADDR, 32'h0000_0b0d, 4'hf, 0, resp);
    check_value("exit resp", 32'(`MEM_RESP_OKAY), 32'(resp));
    check_value("strobes at b, exit", 32'b01, 32'(strobe_at_b));
    check_value("exit strobes", x + 1, exit_count);
    check_value("exit_value", 32'h0000_0b0d, exit_value);
    write_data(`MEM_HALT_ADDR, 32'hdead_beef, 4'hf, 0, resp);
    check_value("halt resp", 32'(`MEM_RESP_OKAY), 32'(resp));
    check_value("strobes at b, halt", 32'b01, 32'(strobe_at_b));
    check_value("exit strobes", x + 2, exit_count);
    check_value("exit_value on halt", 0, exit_value);
    check_value("print strobes", p + 1, print_count);
    expect_ram(32'h0, 0);
    expect_ram(32'h4, 0);
    expect_ram(32'h10, 0);
    report_test("hook writes", e);
  endtask

  task automatic out_of_range();
    int         e;
    int         p;
    int         x;
    logic [1:0] resp;
    e = errors;
    store_word(32'h8, $random(seed), 4'hf, 0);    // in-range alias of 0x1008
    p = print_count;
    x = exit_count;
    write_data(32'h0000_1008, 32'hffff_ffff, 4'hf, 0, resp);
    check_value("oor write resp", 32'(`MEM_RESP_SLVERR), 32'(resp));
    check_value("strobes at b, oor", 0, 32'(strobe_at_b));
    expect_ram(32'h8, 0);
    expect_slverr(1'b1, 32'h0000_1008);
    expect_slverr(1'b0, 32'h0000_1008);
    expect_slverr(1'b0, 32'h8000_0000);
    expect_slverr(1'b0, `MEM_PRINT_ADDR);          // hooks are write only
    expect_slverr(1'b0, `MEM_EXIT_ADDR);
    expect_slverr(1'b0, `MEM_HALT_ADDR);
    expect_slverr(1'b1, `MEM_EXIT_ADDR);
    check_value("print strobes", p, print_count);
    check_value("exit strobes", x, exit_count);
    report_test("out of range", e);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    iar_valid   = 1'b0;
    iar         = '0;
    ir_ready    = 1'b0;
    dar_valid   = 1'b0;
    dar         = '0;
    dr_ready    = 1'b0;
    daw_valid   = 1'b0;
    daw         = '0;
    dw_valid    = 1'b0;
    dw          = '0;
    db_ready    = 1'b0;
    seed        = 32'h31e9_fc7d;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    print_count = 0;
    exit_count  = 0;
    strobe_at_b = '0;
    @(negedge reset);
    @(negedge clk);
    check_reset_state();
    full_word_rw();
    byte_lane_writes();
    back_pressure();
    hook_writes();
    out_of_range();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,  // full clock period
  parameter int RESET_CYCLES = 16   // rising edges spent in reset
) (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, same as every other dut input
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* axi_mm_ram.sv */
`include "mem_params.svh"

module axi_mm_ram (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // ----------------------------------------
  // instruction port, read only
  // ----------------------------------------
  input  logic                   iar_valid_i,
  output logic                   iar_ready_o,
  input  mem_pkg::addr_req_t     iar_i,
  output logic                   ir_valid_o,
  input  logic                   ir_ready_i,
  output mem_pkg::rdata_t        ir_o,
  // ----------------------------------------
  // data port
  // ----------------------------------------
  input  logic                   dar_valid_i,
  output logic                   dar_ready_o,
  input  mem_pkg::addr_req_t     dar_i,
  output logic                   dr_valid_o,
  input  logic                   dr_ready_i,
  output mem_pkg::rdata_t        dr_o,
  input  logic                   daw_valid_i,
  output logic                   daw_ready_o,
  input  mem_pkg::addr_req_t     daw_i,
  input  logic                   dw_valid_i,
  output logic                   dw_ready_o,
  input  mem_pkg::wdata_t        dw_i,
  output logic                   db_valid_o,
  input  logic                   db_ready_i,
  output mem_pkg::bresp_t        db_o,
  // hooks
  output logic                   print_valid_o,
  output logic [7:0]             print_char_o,
  output logic                   exit_valid_o,
  output logic [`MEM_DATA_W-1:0] exit_value_o
);

  logic                    ram_a_en;      // instruction fetch side
  logic [`MEM_INDEX_W-1:0] ram_a_index;
  logic [`MEM_DATA_W-1:0]  ram_a_rdata;
  logic                    ram_b_en;      // load/store side
  logic [`MEM_STRB_W-1:0]  ram_b_we;
  logic [`MEM_INDEX_W-1:0] ram_b_index;
  logic [`MEM_DATA_W-1:0]  ram_b_wdata;
  logic [`MEM_DATA_W-1:0]  ram_b_rdata;
  logic                    hook_valid;
  logic [`MEM_ADDR_W-1:0]  hook_addr;
  logic [`MEM_DATA_W-1:0]  hook_data;

  dp_byte_ram u_ram (
    .clk_i    (clk_i),
    .en_a_i   (ram_a_en),
    .we_a_i   ('0),           // port a never writes
    .index_a_i(ram_a_index),
    .wdata_a_i('0),
    .rdata_a_o(ram_a_rdata),
    .en_b_i   (ram_b_en),
    .we_b_i   (ram_b_we),
    .index_b_i(ram_b_index),
    .wdata_b_i(ram_b_wdata),
    .rdata_b_o(ram_b_rdata)
  );

  axi_read_port u_iport (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ar_valid_i (iar_valid_i),
    .ar_ready_o (iar_ready_o),
    .ar_i       (iar_i),
    .r_valid_o  (ir_valid_o),
    .r_ready_i  (ir_ready_i),
    .r_o        (ir_o),
    .ram_en_o   (ram_a_en),
    .ram_index_o(ram_a_index),
    .ram_rdata_i(ram_a_rdata)
  );

  data_port_ctrl u_dport (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ar_valid_i  (dar_valid_i),
    .ar_ready_o  (dar_ready_o),
    .ar_i        (dar_i),
    .r_valid_o   (dr_valid_o),
    .r_ready_i   (dr_ready_i),
    .r_o         (dr_o),
    .aw_valid_i  (daw_valid_i),
    .aw_ready_o  (daw_ready_o),
    .aw_i        (daw_i),
    .w_valid_i   (dw_valid_i),
    .w_ready_o   (dw_ready_o),
    .w_i         (dw_i),
    .b_valid_o   (db_valid_o),
    .b_ready_i   (db_ready_i),
    .b_o         (db_o),
    .ram_en_o    (ram_b_en),
    .ram_we_o    (ram_b_we),
    .ram_index_o (ram_b_index),
    .ram_wdata_o (ram_b_wdata),
    .ram_rdata_i (ram_b_rdata),
    .hook_valid_o(hook_valid),
    .hook_addr_o (hook_addr),
    .hook_data_o (hook_data)
  );

  mmio_sink u_mmio (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .hook_valid_i (hook_valid),
    .hook_addr_i  (hook_addr),
    .hook_data_i  (hook_data),
    .print_valid_o(print_valid_o),
    .print_char_o (print_char_o),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

endmodule

/* mmio_sink.sv */
`include "mem_params.svh"

module mmio_sink (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   hook_valid_i,  // one cycle per hook write
  input  logic [`MEM_ADDR_W-1:0] hook_addr_i,
  input  logic [`MEM_DATA_W-1:0] hook_data_i,
  output logic                   print_valid_o,
  output logic [7:0]             print_char_o,
  output logic                   exit_valid_o,
  output logic [`MEM_DATA_W-1:0] exit_value_o
);

  // strobes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      print_valid_o <= 1'b0;
      exit_valid_o  <= 1'b0;
    end else begin
      print_valid_o <= hook_valid_i && (hook_addr_i == `MEM_PRINT_ADDR);
      exit_valid_o  <= hook_valid_i && ((hook_addr_i == `MEM_EXIT_ADDR) ||
                                        (hook_addr_i == `MEM_HALT_ADDR));
    end
  end

  // payloads, only meaningful with their strobe
  always_ff @(posedge clk_i) begin
    if (hook_valid_i) begin
      case (hook_addr_i)
        `MEM_PRINT_ADDR: print_char_o <= hook_data_i[7:0];  // low byte only
        `MEM_EXIT_ADDR:  exit_value_o <= hook_data_i;
        `MEM_HALT_ADDR:  exit_value_o <= '0;                // halt means clean exit
        default: ;
      endcase
    end
  end

  a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    !(print_valid_o && exit_valid_o));

endmodule

/* data_port_ctrl.sv */
`include "mem_params.svh"

module data_port_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // read channels
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  mem_pkg::addr_req_t      ar_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output mem_pkg::rdata_t         r_o,
  // write channels
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  mem_pkg::addr_req_t      aw_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  mem_pkg::wdata_t         w_i,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output mem_pkg::bresp_t         b_o,
  // ram port b, shared by reads and writes
  output logic                    ram_en_o,
  output logic [`MEM_STRB_W-1:0]  ram_we_o,
  output logic [`MEM_INDEX_W-1:0] ram_index_o,
  output logic [`MEM_DATA_W-1:0]  ram_wdata_o,
  input  logic [`MEM_DATA_W-1:0]  ram_rdata_i,
  // toward the hook sink
  output logic                    hook_valid_o,
  output logic [`MEM_ADDR_W-1:0]  hook_addr_o,
  output logic [`MEM_DATA_W-1:0]  hook_data_o
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_EXEC,  // ram write or hook strobe
    W_RESP   // b_valid held until b_ready
  } wstate_t;

  wstate_t            wr_state_q;
  mem_pkg::mem_addr_u waddr_q;     // captured aw address
  mem_pkg::wdata_t    wdata_q;     // captured w beat
  logic               write_go;    // joint aw/w handshake this cycle
  logic               wr_exec;
  logic               wr_hit;      // write lands in ram
  logic               wr_hook;     // write lands on a hook address

  logic                    rd_ar_valid;  // gated toward the read engine
  logic                    rd_ar_ready;  // read engine idle
  logic                    rd_ram_en;
  logic [`MEM_INDEX_W-1:0] rd_ram_index;

  // ----------------------------------------
  // arbitration, write wins, one pending
  // ----------------------------------------
  assign write_go    = aw_valid_i && w_valid_i && (wr_state_q == W_IDLE) && rd_ar_ready;
  assign aw_ready_o  = write_go;  // aw and w always taken together
  assign w_ready_o   = write_go;
  assign rd_ar_valid = ar_valid_i && (wr_state_q == W_IDLE) && !write_go;
  assign ar_ready_o  = rd_ar_ready && (wr_state_q == W_IDLE) && !write_go;

  // read side has the same timing and decode as the instruction port
  axi_read_port u_read (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ar_valid_i (rd_ar_valid),
    .ar_ready_o (rd_ar_ready),
    .ar_i       (ar_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_o        (r_o),
    .ram_en_o   (rd_ram_en),
    .ram_index_o(rd_ram_index),
    .ram_rdata_i(ram_rdata_i)
  );

  // ----------------------------------------
  // write decode and ram port sharing
  // ----------------------------------------
  assign wr_exec = (wr_state_q == W_EXEC);
  assign wr_hit  = mem_pkg::in_ram(waddr_q);
  assign wr_hook = waddr_q.flat inside {`MEM_PRINT_ADDR, `MEM_EXIT_ADDR, `MEM_HALT_ADDR};

  assign ram_en_o    = rd_ram_en || (wr_exec && wr_hit);  // never both, one pending
  assign ram_we_o    = (wr_exec && wr_hit) ? wdata_q.strb : '0;
  assign ram_index_o = wr_exec ? waddr_q.ram.index : rd_ram_index;
  assign ram_wdata_o = wdata_q.data;

  assign hook_valid_o = wr_exec && wr_hook;  // one cycle, sink registers it
  assign hook_addr_o  = waddr_q.flat;
  assign hook_data_o  = wdata_q.data;

  assign b_valid_o = (wr_state_q == W_RESP);
  assign b_o       = (wr_hit || wr_hook) ? `MEM_RESP_OKAY : `MEM_RESP_SLVERR;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= W_IDLE;
    end else begin
      case (wr_state_q)
        W_IDLE: if (write_go) wr_state_q <= W_EXEC;
        W_EXEC: wr_state_q <= W_RESP;             // ram written at this edge
        W_RESP: if (b_ready_i) wr_state_q <= W_IDLE;
        default: wr_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_go) begin
      waddr_q <= aw_i.addr;
      wdata_q <= w_i;
    end
  end

  a_aw_with_w: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_valid_i && aw_ready_o |-> w_valid_i && w_ready_o);

  // only one transaction at a time, so responses cannot start together
  a_one_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    !($rose(b_valid_o) && $rose(r_valid_o)));

endmodule

/* axi_read_port.sv */
`include "mem_params.svh"

module axi_read_port (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // read address channel
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  mem_pkg::addr_req_t      ar_i,
  // read data channel
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output mem_pkg::rdata_t         r_o,
  // ram port, read only
  output logic                    ram_en_o,
  output logic [`MEM_INDEX_W-1:0] ram_index_o,
  input  logic [`MEM_DATA_W-1:0]  ram_rdata_i
);

  // idle, then read cycle in ram, then response held until taken
  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_RESP
  } state_t;

  state_t             state_q;
  logic               r_valid_q;  // response registered and on the bus
  mem_pkg::mem_addr_u addr_q;     // captured request address
  logic               hit;        // request inside the ram window

  assign hit         = mem_pkg::in_ram(addr_q);
  assign ar_ready_o  = (state_q == S_IDLE);  // one outstanding read
  assign ram_en_o    = (state_q == S_READ) && hit;  // no ram access on slverr
  assign ram_index_o = addr_q.ram.index;
  assign r_valid_o   = r_valid_q;

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= S_IDLE;
      r_valid_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (ar_valid_i) state_q <= S_READ;  // ready is high in idle
        S_READ: state_q <= S_RESP;                  // ram samples index here
        S_RESP: begin
          if (!r_valid_q) begin
            r_valid_q <= 1'b1;                      // data loaded this edge
          end else if (r_ready_i) begin
            r_valid_q <= 1'b0;                      // r handshake
            state_q   <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // payload
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      addr_q <= ar_i.addr;
    end
    if ((state_q == S_RESP) && !r_valid_q) begin
      r_o.data <= hit ? ram_rdata_i : '0;                   // zero data out of range
      r_o.resp <= hit ? `MEM_RESP_OKAY : `MEM_RESP_SLVERR;
    end
  end

  // response must not change under back-pressure
  a_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

endmodule

/* dp_byte_ram.sv */
`include "mem_params.svh"

module dp_byte_ram (
  input  logic                    clk_i,
  // port a
  input  logic                    en_a_i,     // access enable
  input  logic [`MEM_STRB_W-1:0]  we_a_i,     // per-lane write enable
  input  logic [`MEM_INDEX_W-1:0] index_a_i,  // word index
  input  logic [`MEM_DATA_W-1:0]  wdata_a_i,
  output logic [`MEM_DATA_W-1:0]  rdata_a_o,  // valid one cycle after en
  // port b
  input  logic                    en_b_i,
  input  logic [`MEM_STRB_W-1:0]  we_b_i,
  input  logic [`MEM_INDEX_W-1:0] index_b_i,
  input  logic [`MEM_DATA_W-1:0]  wdata_b_i,
  output logic [`MEM_DATA_W-1:0]  rdata_b_o
);

  localparam int LANE_W = `MEM_DATA_W / `MEM_STRB_W;  // 8 bit lanes
  localparam int DEPTH  = 1 << `MEM_INDEX_W;

  logic [`MEM_DATA_W-1:0] mem [DEPTH];  // no preload, filled through data port

  // both ports in one process, read-before-write on each port
  always_ff @(posedge clk_i) begin
    if (en_a_i) begin
      for (int i = 0; i < `MEM_STRB_W; i++) begin
        if (we_a_i[i]) begin
          mem[index_a_i][i*LANE_W +: LANE_W] <= wdata_a_i[i*LANE_W +: LANE_W];
        end
      end
      rdata_a_o <= mem[index_a_i];  // old data on a same-cycle write
    end
    if (en_b_i) begin
      for (int i = 0; i < `MEM_STRB_W; i++) begin
        if (we_b_i[i]) begin
          mem[index_b_i][i*LANE_W +: LANE_W] <= wdata_b_i[i*LANE_W +: LANE_W];
        end
      end
      rdata_b_o <= mem[index_b_i];  // holds while en_b_i is low
    end
  end

  // colliding writes from both ports would leave the word undefined
  a_no_dual_write: assert property (@(posedge clk_i)
    !(en_a_i && en_b_i && (|we_a_i) && (|we_b_i) && (index_a_i == index_b_i)));

endmodule

/* mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

  // byte offset bits inside one word
  localparam int OFFSET_W = $clog2(`MEM_STRB_W);
  // everything above the ram index, zero for a ram hit
  localparam int TAG_W = `MEM_ADDR_W - `MEM_INDEX_W - OFFSET_W;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;  // byte address of the beat
  } addr_req_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;  // write word
    logic [`MEM_STRB_W-1:0] strb;  // one bit per byte lane
  } wdata_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;  // zero on slverr
    logic [1:0]             resp;  // okay or slverr
  } rdata_t;

  typedef logic [1:0] bresp_t;     // write response code

  // ----------------------------------------
  // address decode views
  // ----------------------------------------
  typedef struct packed {
    logic [TAG_W-1:0]       tag;     // must be zero to reach ram
    logic [`MEM_INDEX_W-1:0] index;  // ram word index
    logic [OFFSET_W-1:0]    offset;  // byte within word, ignored by ram
  } ram_addr_t;

  // same address word, compared whole against hooks
  // or split into tag/index/offset for the ram
  typedef union packed {
    logic [`MEM_ADDR_W-1:0] flat;
    ram_addr_t              ram;
  } mem_addr_u;

  // true when the address lands inside the ram window
  function automatic logic in_ram(mem_addr_u a);
    return a.ram.tag == '0;
  endfunction

endpackage

/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define MEM_ADDR_W 32       // byte address
`define MEM_DATA_W 32       // one word per beat
`define MEM_STRB_W 4        // byte lanes per word

// ----------------------------------------
// ram window, starts at address zero
// ----------------------------------------
`define MEM_INDEX_W 10      // 1024 words = 4 KiB

// ----------------------------------------
// memory-mapped hooks, data port only
// ----------------------------------------
`define MEM_PRINT_ADDR 32'h1000_0000   // low byte goes to console
`define MEM_EXIT_ADDR  32'h2000_0004   // exit with written value
`define MEM_HALT_ADDR  32'h2000_0010   // exit with value zero

// axi response codes
`define MEM_RESP_OKAY   2'd0
`define MEM_RESP_SLVERR 2'd2

`endif
